// File: design/video_pkg.sv
/*
	video pattern package
	frame geometry, pattern modes and the stream, config and stats types
*/
package video_pkg;

	// ----------------------------------------
	// stream geometry
	// ----------------------------------------

	// bits per pixel channel
	localparam int DATA_WIDTH  = 12;
	// parallel pixels per clock
	localparam int CHANNEL_NUM = 4;
	// width of the width and line-count fields
	localparam int GEOM_WIDTH  = 8;
	// lval low between lines
	localparam int H_BLANK     = 4;
	// fval high before first lval
	localparam int V_BLANK     = 3;
	// in-line position field, line-increment mode
	localparam int NIBBLE_W    = 4;

	// ----------------------------------------
	// pattern modes
	// ----------------------------------------

	typedef enum logic [1:0] {
		MODE_LINE_INC,
		MODE_FRAME_INC,
		MODE_PIX_INC,
		MODE_PIX_INC_NO_FVAL
	} pattern_mode_e;

	// one pixel word, read as a plain count
	// or as line index over in-line position
	typedef union packed {
		logic [DATA_WIDTH-1:0] count;
		struct packed {
			// line index within the frame
			logic [DATA_WIDTH-NIBBLE_W-1:0] line;
			// word position, wraps mod 16
			logic [NIBBLE_W-1:0]            pos;
		} li;
	} pixel_u;

	// ----------------------------------------
	// config and stream
	// ----------------------------------------

	// held stable while busy
	typedef struct packed {
		pattern_mode_e         mode;
		// active words per line
		logic [GEOM_WIDTH-1:0] width;
		// lines per frame
		logic [GEOM_WIDTH-1:0] lines;
	} video_cfg_t;

	// fval/lval framing plus all channels
	typedef struct packed {
		logic                       fval;
		logic                       lval;
		pixel_u [CHANNEL_NUM-1:0]   data;
	} video_bus_t;

	// per-frame results
	typedef struct packed {
		// sum of all channel values, mod 2^32
		logic [31:0]           checksum;
		// valid words in the frame
		logic [15:0]           words;
		// lval falling edges in the frame
		logic [GEOM_WIDTH-1:0] lines;
	} frame_stats_t;

endpackage

// File: design/sensor_timing.sv
/*
	sensor timing generator
	fval/lval framing for a burst of frames of the configured geometry
*/
module sensor_timing import video_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  video_cfg_t            i_cfg,
	input  logic                  i_start,
	input  logic [GEOM_WIDTH-1:0] i_frames,
	output video_bus_t            o_video,
	output logic                  o_busy
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_VBLANK,
		ST_ACTIVE,
		ST_HBLANK,
		ST_GAP
	} state_e;

	state_e                state;
	// cycle counter inside vblank, active and hblank
	logic [GEOM_WIDTH-1:0] pix_cnt;
	logic [GEOM_WIDTH-1:0] line_cnt;
	// frames still to send in this burst
	logic [GEOM_WIDTH-1:0] frames_left;

	// ----------------------------------------
	// framing FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ST_IDLE;
			pix_cnt     <= '0;
			line_cnt    <= '0;
			frames_left <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// zero-frame requests are dropped
					if (i_start && i_frames != '0) begin
						state       <= ST_VBLANK;
						pix_cnt     <= '0;
						line_cnt    <= '0;
						frames_left <= i_frames;
					end
				end
				ST_VBLANK: begin
					if (pix_cnt == GEOM_WIDTH'(V_BLANK - 1)) begin
						state   <= ST_ACTIVE;
						pix_cnt <= '0;
					end else begin
						pix_cnt <= pix_cnt + 1'b1;
					end
				end
				ST_ACTIVE: begin
					if (pix_cnt == i_cfg.width - 1'b1) begin
						state   <= ST_HBLANK;
						pix_cnt <= '0;
					end else begin
						pix_cnt <= pix_cnt + 1'b1;
					end
				end
				ST_HBLANK: begin
					if (pix_cnt == GEOM_WIDTH'(H_BLANK - 1)) begin
						pix_cnt <= '0;
						if (line_cnt == i_cfg.lines - 1'b1) begin
							// last line done, fval drops next
							line_cnt    <= '0;
							frames_left <= frames_left - 1'b1;
							state       <= (frames_left == GEOM_WIDTH'(1)) ? ST_IDLE : ST_GAP;
						end else begin
							line_cnt <= line_cnt + 1'b1;
							state    <= ST_ACTIVE;
						end
					end else begin
						pix_cnt <= pix_cnt + 1'b1;
					end
				end
				// one cycle of fval low between frames
				ST_GAP: state <= ST_VBLANK;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// outputs, decoded from registered state
	// ----------------------------------------
	always_comb begin
		o_video      = '0;
		o_video.fval = (state == ST_VBLANK) || (state == ST_ACTIVE) || (state == ST_HBLANK);
		o_video.lval = (state == ST_ACTIVE);
		// busy falls together with the last fval
		o_busy       = (state != ST_IDLE);
	end

endmodule

// File: design/pattern_gen.sv
/*
	test pattern generator
	delays the framing by one cycle and fills all channels per the pattern mode
*/
module pattern_gen import video_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  pattern_mode_e i_mode,
	input  video_bus_t    i_video,
	output video_bus_t    o_video
);

	// registered framing, also the output framing
	logic fval_reg;
	logic lval_reg;

	logic fval_rise;
	logic fval_fall;
	logic lval_rise;
	logic lval_fall;

	// per-frame counter for line and pixel increment
	pixel_u pix;
	// pixel count, cleared by reset only
	logic [DATA_WIDTH-1:0] run_cnt;
	// completed frames since reset
	logic [DATA_WIDTH-1:0] frame_cnt;
	// value shown on every channel
	pixel_u value;

	// ----------------------------------------
	// framing register and edges
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fval_reg <= 1'b0;
			lval_reg <= 1'b0;
		end else begin
			fval_reg <= i_video.fval;
			lval_reg <= i_video.lval;
		end
	end

	// edges seen from input vs registered copy
	assign fval_rise = !fval_reg && i_video.fval;
	assign fval_fall = fval_reg && !i_video.fval;
	assign lval_rise = !lval_reg && i_video.lval;
	assign lval_fall = lval_reg && !i_video.lval;

	// ----------------------------------------
	// per-frame counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pix <= '0;
		end else begin
			case (i_mode)
				MODE_LINE_INC: begin
					// line index, cleared at frame start
					if (fval_rise) begin
						pix.li.line <= '0;
					end else if (lval_fall) begin
						pix.li.line <= pix.li.line + 1'b1;
					end
					// position in line, wraps on its own
					if (lval_rise) begin
						pix.li.pos <= '0;
					end else if (lval_reg) begin
						pix.li.pos <= pix.li.pos + 1'b1;
					end
				end
				MODE_PIX_INC: begin
					// held at zero while fval is low
					if (!i_video.fval) begin
						pix.count <= '0;
					end else if (lval_reg) begin
						pix.count <= pix.count + 1'b1;
					end
				end
				default: pix <= pix;
			endcase
		end
	end

	// ----------------------------------------
	// counters that run in every mode
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			run_cnt   <= '0;
			frame_cnt <= '0;
		end else begin
			// one step per output word
			if (lval_reg) begin
				run_cnt <= run_cnt + 1'b1;
			end
			if (fval_fall) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// mode select
	always_comb begin
		case (i_mode)
			MODE_LINE_INC,
			MODE_PIX_INC:   value = pix;
			MODE_FRAME_INC: value.count = frame_cnt;
			default:        value.count = run_cnt;
		endcase
	end

	// ----------------------------------------
	// output, data zero outside lval
	// ----------------------------------------
	always_comb begin
		o_video.fval = fval_reg;
		o_video.lval = lval_reg;
		for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
			o_video.data[ch] = lval_reg ? value : '0;
		end
	end

endmodule

// File: design/frame_stats.sv
/*
	frame statistics
	per-frame checksum, word and line counts, reported at frame end
*/
module frame_stats import video_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  video_bus_t   i_video,
	output frame_stats_t o_stats,
	output logic         o_stats_valid
);

	// previous framing for edge detect
	logic fval_d;
	logic lval_d;
	logic fval_fall;
	logic lval_fall;

	// sum of all channels in the current word
	logic [31:0] word_sum;

	// running accumulators
	logic [31:0]           acc_sum;
	logic [15:0]           acc_words;
	logic [GEOM_WIDTH-1:0] acc_lines;

	assign fval_fall = fval_d && !i_video.fval;
	assign lval_fall = lval_d && !i_video.lval;

	always_comb begin
		word_sum = '0;
		for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
			word_sum = word_sum + 32'(i_video.data[ch].count);
		end
	end

	// ----------------------------------------
	// accumulate during fval
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fval_d        <= 1'b0;
			lval_d        <= 1'b0;
			acc_sum       <= '0;
			acc_words     <= '0;
			acc_lines     <= '0;
			o_stats_valid <= 1'b0;
		end else begin
			fval_d        <= i_video.fval;
			lval_d        <= i_video.lval;
			o_stats_valid <= fval_fall;
			if (fval_fall) begin
				// frame done, start over
				acc_sum   <= '0;
				acc_words <= '0;
				acc_lines <= '0;
			end else if (i_video.fval) begin
				if (i_video.lval) begin
					acc_sum   <= acc_sum + word_sum;
					acc_words <= acc_words + 1'b1;
				end
				if (lval_fall) begin
					acc_lines <= acc_lines + 1'b1;
				end
			end
		end
	end

	// results held until the next frame end
	always_ff @(posedge clk) begin
		if (fval_fall) begin
			o_stats.checksum <= acc_sum;
			o_stats.words    <= acc_words;
			o_stats.lines    <= acc_lines;
		end
	end

endmodule

// File: design/pattern_top.sv
/*
	pattern source top
	timing generator, pattern generator and frame statistics in a chain
*/
module pattern_top import video_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  video_cfg_t            i_cfg,
	input  logic                  i_start,
	input  logic [GEOM_WIDTH-1:0] i_frames,
	output video_bus_t            o_video,
	output logic                  o_busy,
	output frame_stats_t          o_stats,
	output logic                  o_stats_valid
);

	// framing only, data is zero
	video_bus_t timing_video;

	// ----------------------------------------
	// framing source
	// ----------------------------------------
	sensor_timing sensor_timing_inst (
		.clk      (clk),
		.reset    (reset),
		.i_cfg    (i_cfg),
		.i_start  (i_start),
		.i_frames (i_frames),
		.o_video  (timing_video),
		.o_busy   (o_busy)
	);

	// one cycle behind the timing block
	pattern_gen pattern_gen_inst (
		.clk     (clk),
		.reset   (reset),
		.i_mode  (i_cfg.mode),
		.i_video (timing_video),
		.o_video (o_video)
	);

	// watches the top-level stream
	frame_stats frame_stats_inst (
		.clk           (clk),
		.reset         (reset),
		.i_video       (o_video),
		.o_stats       (o_stats),
		.o_stats_valid (o_stats_valid)
	);

endmodule

// File: bench/pattern_model.svh
/*
	pattern reference model
	expected pixel values, frame length and frame statistics from the mode rules
*/
`ifndef PATTERN_MODEL_SVH
`define PATTERN_MODEL_SVH

// value on every channel of one valid word
function automatic logic [DATA_WIDTH-1:0] expected_pixel(input pattern_mode_e mode,
		input int word, input int line, input int pos, input int run, input int done);
	case (mode)
		// line index over position, position wraps mod 16
		MODE_LINE_INC:  return DATA_WIDTH'((line << NIBBLE_W) + (pos % (1 << NIBBLE_W)));
		MODE_FRAME_INC: return DATA_WIDTH'(done);
		MODE_PIX_INC:   return DATA_WIDTH'(word);
		// running count since reset
		default:        return DATA_WIDTH'(run);
	endcase
endfunction

// fval high cycles for one frame
function automatic int frame_length(input video_cfg_t c);
	return V_BLANK + int'(c.lines) * (int'(c.width) + H_BLANK);
endfunction

// stats for a whole frame, given the running counters at its start
function automatic frame_stats_t expected_stats(input video_cfg_t c, input int run_start,
		input int frame_base);
	frame_stats_t s;
	logic [31:0]  sum;
	int           word;
	sum = '0;
	for (int ln = 0; ln < int'(c.lines); ln++) begin
		for (int p = 0; p < int'(c.width); p++) begin
			word = ln * int'(c.width) + p;
			sum  = sum + CHANNEL_NUM * 32'(expected_pixel(c.mode, word, ln, p,
				run_start + word, frame_base));
		end
	end
	s.checksum = sum;
	s.words    = 16'(int'(c.width) * int'(c.lines));
	s.lines    = c.lines;
	return s;
endfunction

`endif

// File: bench/tb_pattern.sv
/*
	testbench for the pattern source
	runs a table of mode and geometry rows, checks pixels, framing and stats
*/
module tb_pattern import video_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	`include "pattern_model.svh"

	// one stimulus row
	typedef struct packed {
		video_cfg_t            cfg;
		logic [GEOM_WIDTH-1:0] frames;
	} row_t;

	localparam int ROW_NUM = 6;

	logic                  clk;
	logic                  reset;
	video_cfg_t            cfg;
	logic                  start;
	logic [GEOM_WIDTH-1:0] frames;
	video_bus_t            video;
	logic                  busy;
	frame_stats_t          stats;
	logic                  stats_valid;

	row_t   rows [ROW_NUM];
	integer seed;
	int     errors;
	int     rows_failed;
	int     cycle_cnt;
	int     timeout_limit;
	int     stats_seen;

	// model state advanced by the monitor
	video_cfg_t            cur_cfg;
	int                    run_words;
	int                    frames_done;
	int                    frame_word;
	int                    line_idx;
	int                    line_pos;
	int                    run_start;
	int                    frame_base;
	int                    fval_len;
	int                    lval_len;
	logic                  fval_prev;
	logic                  lval_prev;
	logic                  stats_due;
	frame_stats_t          exp_stats;
	logic [DATA_WIDTH-1:0] exp_pix;

	pattern_top pattern_top_inst (
		.clk           (clk),
		.reset         (reset),
		.i_cfg         (cfg),
		.i_start       (start),
		.i_frames      (frames),
		.o_video       (video),
		.o_busy        (busy),
		.o_stats       (stats),
		.o_stats_valid (stats_valid)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// timeout
	// ----------------------------------------
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit) begin
			$display("timeout after %0d cycles, the DUT never finished the table", cycle_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string sig, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAIL %s: expected 0x%0h, got 0x%0h at %0t", sig, expected, actual, $time);
		errors++;
	endtask

	// ----------------------------------------
	// monitor sampling at each rising edge
	// ----------------------------------------
	always @(posedge clk) begin
		if (!reset) begin
			// stats pulse one cycle after the top fval fall
			assert (stats_valid == stats_due)
				else report_mismatch("o_stats_valid", 32'(stats_due), 32'(stats_valid));
			if (stats_valid && stats_due) begin
				assert (stats.checksum == exp_stats.checksum)
					else report_mismatch("o_stats.checksum", exp_stats.checksum,
						stats.checksum);
				assert (stats.words == exp_stats.words)
					else report_mismatch("o_stats.words", 32'(exp_stats.words),
						32'(stats.words));
				assert (stats.lines == exp_stats.lines)
					else report_mismatch("o_stats.lines", 32'(exp_stats.lines),
						32'(stats.lines));
			end
			if (stats_valid) begin
				stats_seen++;
			end
			stats_due = 1'b0;

			// frame start takes a snapshot of the running counters
			if (video.fval && !fval_prev) begin
				frame_word = 0;
				line_idx   = 0;
				line_pos   = 0;
				fval_len   = 0;
				run_start  = run_words;
				frame_base = frames_done;
			end
			if (video.fval) begin
				fval_len++;
			end

			if (video.lval) begin
				exp_pix = expected_pixel(cur_cfg.mode, frame_word, line_idx, line_pos,
					run_words, frames_done);
				for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
					assert (video.data[ch].count == exp_pix)
						else report_mismatch($sformatf("o_video.data[%0d]", ch),
							32'(exp_pix), 32'(video.data[ch].count));
				end
				frame_word++;
				line_pos++;
				run_words++;
				lval_len++;
			end else begin
				// blanking carries zero data
				for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
					assert (video.data[ch].count == '0)
						else report_mismatch($sformatf("o_video.data[%0d]", ch),
							32'd0, 32'(video.data[ch].count));
				end
				// end of a line
				if (lval_prev) begin
					assert (lval_len == int'(cur_cfg.width))
						else report_mismatch("o_video.lval length", 32'(cur_cfg.width),
							32'(lval_len));
					line_idx++;
					line_pos = 0;
					lval_len = 0;
				end
			end

			// at frame end the stats are due next cycle
			if (!video.fval && fval_prev) begin
				assert (fval_len == frame_length(cur_cfg))
					else report_mismatch("o_video.fval length", 32'(frame_length(cur_cfg)),
						32'(fval_len));
				exp_stats = expected_stats(cur_cfg, run_start, frame_base);
				stats_due = 1'b1;
				frames_done++;
			end
			fval_prev = video.fval;
			lval_prev = video.lval;
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic set_row(input int r, input pattern_mode_e mode, input int width,
			input int lines, input int nframes);
		rows[r].cfg.mode  = mode;
		rows[r].cfg.width = GEOM_WIDTH'(width);
		rows[r].cfg.lines = GEOM_WIDTH'(lines);
		rows[r].frames    = GEOM_WIDTH'(nframes);
	endtask

	// nothing moves before the first start
	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (!busy) else report_mismatch("o_busy", 32'd0, 32'(busy));
			assert (!stats_valid)
				else report_mismatch("o_stats_valid", 32'd0, 32'(stats_valid));
			assert (!video.fval) else report_mismatch("o_video.fval", 32'd0, 32'(video.fval));
			assert (!video.lval) else report_mismatch("o_video.lval", 32'd0, 32'(video.lval));
		end
	endtask

	task automatic run_row(input int r);
		int errors_before;
		errors_before = errors;
		@(negedge clk);
		cur_cfg    = rows[r].cfg;
		cfg        = rows[r].cfg;
		frames     = rows[r].frames;
		stats_seen = 0;
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// start taken on the rising edge just passed
		assert (busy) else report_mismatch("o_busy", 32'd1, 32'(busy));
		// burst over once busy drops and every frame has reported
		while (busy || stats_seen < int'(rows[r].frames)) begin
			@(negedge clk);
		end
		if (errors == errors_before) begin
			$display("row %0d %s width %0d lines %0d frames %0d: ok", r,
				rows[r].cfg.mode.name(), rows[r].cfg.width, rows[r].cfg.lines,
				rows[r].frames);
		end else begin
			rows_failed++;
			$display("row %0d %s width %0d lines %0d frames %0d: %0d errors", r,
				rows[r].cfg.mode.name(), rows[r].cfg.width, rows[r].cfg.lines,
				rows[r].frames, errors - errors_before);
		end
	endtask

	initial begin
		seed        = 32'hb087_689e;
		reset       = 1'b1;
		start       = 1'b0;
		cfg         = '0;
		frames      = '0;
		fval_prev   = 1'b0;
		lval_prev   = 1'b0;
		stats_due   = 1'b0;
		errors      = 0;
		rows_failed = 0;
		cur_cfg     = '0;

		// mode, width, lines, frames
		set_row(0, MODE_PIX_INC,         6,  3, 2);
		set_row(1, MODE_PIX_INC_NO_FVAL, 5,  2, 2);
		set_row(2, MODE_LINE_INC,        20, 3, 1);
		set_row(3, MODE_FRAME_INC,       4,  2, 3);
		set_row(4, MODE_PIX_INC_NO_FVAL, 3,  4, 1);
		// width drawn from the seed
		set_row(5, MODE_PIX_INC,         4 + ($random(seed) & 15), 2, 2);

		timeout_limit = 50;
		for (int r = 0; r < ROW_NUM; r++) begin
			timeout_limit += int'(rows[r].frames) * (int'(rows[r].cfg.lines) *
				(int'(rows[r].cfg.width) + H_BLANK) + V_BLANK + 2);
		end

		// reset for 4 cycles
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_idle(3);

		for (int r = 0; r < ROW_NUM; r++) begin
			run_row(r);
		end

		$display("rows run %0d, rows failed %0d, errors %0d", ROW_NUM, rows_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+bench
design/video_pkg.sv
design/sensor_timing.sv
design/pattern_gen.sv
design/frame_stats.sv
design/pattern_top.sv
bench/tb_pattern.sv

// File: Makefile
# Verilator build and run for the pattern source testbench

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/100ps
TOP        = tb_pattern
FILELIST   = tb.f
OBJ_DIR    = obj_dir
PASS_MSG   = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
